// File: list.f
hw/ex_types_pkg.sv
hw/ex_op_pkg.sv
hw/ex_op_if.sv
hw/int_alu.sv
hw/muldiv_unit.sv
hw/ex_ctrl.sv
hw/ex_unit.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_ex_unit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the ex_unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
    --top-module tb_ex_unit \
    --Mdir obj_dir \
    -f list.f

./obj_dir/Vtb_ex_unit | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    localparam int          ACK_TIMEOUT = 400;  // cycles
    localparam logic [31:0] SEED        = 32'he64c_d28d;

    logic   clk;
    logic   rst;
    logic   req;
    ex_op_e op;
    xlen_t  src1;
    xlen_t  src2;
    logic   ack;
    xlen_t  result;
    logic   cond;

    logic [31:0] rng_state;
    int          timeouts;
    logic        timed_out;

    ex_op_e alu_ops [15] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
                             ADDW, SUBW, SLLW, SRLW, SRAW};
    ex_op_e br_ops [6]   = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    ex_op_e md_ops [10]  = '{MUL, MULW, DIV, DIVU, REM, REMU, DIVW, DIVUW, REMW, REMUW};

    tb_clkgen #(.PERIOD_NS(20)) clkgen (.clk(clk));

    ex_unit #(
        .MD_BITS_PER_CYCLE (2)
    ) dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .ack    (ack),
        .result (result),
        .cond   (cond)
    );

    tb_checker chk (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .ack    (ack),
        .result (result),
        .cond   (cond)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // about one in four operands is a corner value
    function automatic xlen_t rand_operand();
        logic [31:0] r;
        logic [31:0] lo_w;
        r = next_rand();
        if (r[1:0] != 2'd0) return {next_rand(), next_rand()};
        case (r[3:2])
            2'd0:    return '0;
            2'd1:    return '1;
            2'd2:    return XLEN_MIN;
            default: begin
                lo_w = next_rand();
                return {next_rand(), 1'b1, lo_w[30:0]};
            end
        endcase
    endfunction

    function automatic int rand_index(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    task automatic wait_for_ack(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (ack !== level && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack !== level) begin
            $display("timeout: ack did not %s within %0d cycles for op %s",
                     what, ACK_TIMEOUT, op.name());
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // one full four-phase exchange, called at a falling edge
    task automatic run_transaction(input ex_op_e o, input xlen_t a, input xlen_t b,
                                   input int hold);
        if (timed_out) return;
        op   = o;
        src1 = a;
        src2 = b;
        req  = 1'b1;
        wait_for_ack(1'b1, "rise");
        if (timed_out) begin
            req = 1'b0;
            return;
        end
        repeat (hold) @(negedge clk);  // back-pressure
        req = 1'b0;
        wait_for_ack(1'b0, "fall");
    endtask

    initial begin
        int          i;
        xlen_t       a;
        xlen_t       b;
        logic [31:0] r;
        rst       = 1'b1;
        req       = 1'b0;
        op        = ADD;
        src1      = '0;
        src2      = '0;
        rng_state = SEED;
        timeouts  = 0;
        timed_out = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);  // idle outputs checked here

        for (i = 0; i < 300; i++) begin
            run_transaction(alu_ops[rand_index(15)], rand_operand(), rand_operand(), 0);
        end
        for (i = 0; i < 200; i++) begin
            r = next_rand();
            a = rand_operand();
            b = (r[1:0] == 2'd0) ? a : rand_operand();
            run_transaction(br_ops[rand_index(6)], a, b, 0);
        end
        for (i = 0; i < 200; i++) begin
            a = rand_operand();
            b = rand_operand();
            case (i % 8)
                0: b = {next_rand(), 32'h0};  // zero divisor for W forms
                1: begin
                    a = XLEN_MIN;
                    b = '1;
                end
                2: begin
                    a = {next_rand(), 32'h8000_0000};
                    b = {next_rand(), 32'hffff_ffff};
                end
                3: b = '0;
                default: ;
            endcase
            run_transaction(md_ops[rand_index(10)], a, b, 0);
        end
        for (i = 0; i < 60; i++) begin
            if (i % 2 == 0) begin
                run_transaction(alu_ops[rand_index(15)], rand_operand(), rand_operand(),
                                1 + rand_index(12));
            end else begin
                run_transaction(md_ops[rand_index(10)], rand_operand(), rand_operand(),
                                1 + rand_index(12));
            end
        end
        for (i = 0; i < 200; i++) begin
            if (i % 2 == 0) begin
                run_transaction(alu_ops[rand_index(15)], rand_operand(), rand_operand(), 0);
            end else begin
                run_transaction(md_ops[rand_index(10)], rand_operand(), rand_operand(), 0);
            end
        end

        repeat (2) @(negedge clk);
        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 chk.checks, chk.errors, timeouts);
        if (chk.errors == 0 && timeouts == 0 && chk.checks > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                req,
    input wire ex_op_pkg::ex_op_e   op,
    input wire ex_types_pkg::xlen_t src1,
    input wire ex_types_pkg::xlen_t src2,
    input wire logic                ack,
    input wire ex_types_pkg::xlen_t result,
    input wire logic                cond
);
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    int     errors = 0;
    int     checks = 0;
    logic   rst_q = 1'b1;
    logic   req_q = 1'b0;
    logic   ack_q = 1'b0;
    ex_op_e op_q = ADD;
    xlen_t  a_q = '0;
    xlen_t  b_q = '0;
    xlen_t  held_res = '0;
    logic   held_cond = 1'b0;

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // expected result from the RISC-V rules
    function automatic xlen_t ref_result(input ex_op_e o, input xlen_t a, input xlen_t b);
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] t32;
        logic        ovf64;
        logic        ovf32;
        xlen_t       t64;
        a32   = a[31:0];
        b32   = b[31:0];
        ovf64 = (a == XLEN_MIN) && (b == '1);
        ovf32 = (a32 == 32'h8000_0000) && (b32 == 32'hffff_ffff);
        case (o)
            ADD:  return a + b;
            SUB:  return a - b;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLL:  return a << b[5:0];
            SRL:  return a >> b[5:0];
            SRA: begin
                t64 = $signed(a) >>> b[5:0];
                return t64;
            end
            SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU: return (a < b) ? 64'd1 : 64'd0;
            ADDW: begin
                t32 = a32 + b32;
                return sext32(t32);
            end
            SUBW: begin
                t32 = a32 - b32;
                return sext32(t32);
            end
            SLLW: return sext32(a32 << b[4:0]);
            SRLW: return sext32(a32 >> b[4:0]);
            SRAW: begin
                t32 = $signed(a32) >>> b[4:0];
                return sext32(t32);
            end
            MUL:  return a * b;
            MULW: begin
                t32 = a32 * b32;  // only the low half matters
                return sext32(t32);
            end
            DIV: begin
                if (b == '0) return '1;
                if (ovf64) return a;
                t64 = $signed(a) / $signed(b);
                return t64;
            end
            DIVU: return (b == '0) ? '1 : a / b;
            REM: begin
                if (b == '0) return a;
                if (ovf64) return '0;
                t64 = $signed(a) % $signed(b);  // sign follows dividend
                return t64;
            end
            REMU: return (b == '0) ? a : a % b;
            DIVW: begin
                if (b32 == '0) return '1;
                if (ovf32) return sext32(a32);
                t32 = $signed(a32) / $signed(b32);
                return sext32(t32);
            end
            DIVUW: begin
                if (b32 == '0) return '1;
                t32 = a32 / b32;
                return sext32(t32);
            end
            REMW: begin
                if (b32 == '0) return sext32(a32);
                if (ovf32) return '0;
                t32 = $signed(a32) % $signed(b32);
                return sext32(t32);
            end
            REMUW: begin
                if (b32 == '0) return sext32(a32);
                t32 = a32 % b32;
                return sext32(t32);
            end
            default: return '0;  // branches give zero
        endcase
    endfunction

    // taken = 1, non-branch ops give 0
    function automatic logic ref_taken(input ex_op_e o, input xlen_t a, input xlen_t b);
        case (o)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst_q && !rst && !req) begin  // first edge out of reset
            checks = checks + 1;
            if (ack !== 1'b0 || result !== '0 || cond !== 1'b0) begin
                errors = errors + 1;
                $display("[FAIL] %0t: outputs not zero after reset, ack=%b result=%h cond=%b",
                         $time, ack, result, cond);
            end
        end
        if (!rst && req && !req_q) begin
            op_q = op;
            a_q  = src1;
            b_q  = src2;
        end
        if (!rst && ack && !ack_q) begin
            checks = checks + 1;
            if (result !== ref_result(op_q, a_q, b_q) || cond !== ref_taken(op_q, a_q, b_q)) begin
                errors = errors + 1;
                $display("[FAIL] %0t: %s a=%h b=%h got %h/%b expected %h/%b",
                         $time, op_q.name(), a_q, b_q, result, cond,
                         ref_result(op_q, a_q, b_q), ref_taken(op_q, a_q, b_q));
            end
            held_res  = result;
            held_cond = cond;
        end else if (!rst && ack && ack_q) begin  // held under back-pressure
            if (result !== held_res || cond !== held_cond) begin
                errors = errors + 1;
                $display("[FAIL] %0t: %s output changed while ack high, %h/%b -> %h/%b",
                         $time, op_q.name(), held_res, held_cond, result, cond);
            end
        end
        rst_q = rst;
        req_q = req;
        ack_q = ack;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: hw/ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit #(
    parameter int MD_BITS_PER_CYCLE = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  ex_op_pkg::ex_op_e   op,
    input  ex_types_pkg::xlen_t src1,
    input  ex_types_pkg::xlen_t src2,
    output logic                ack,
    output ex_types_pkg::xlen_t result,
    output logic                cond
);

    ex_op_if alu_bus ();
    ex_op_if md_bus ();

    ex_ctrl u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .src1   (src1),
        .src2   (src2),
        .ack    (ack),
        .result (result),
        .cond   (cond),
        .alu    (alu_bus),
        .md     (md_bus)
    );

    int_alu u_alu (
        .clk (clk),
        .rst (rst),
        .bus (alu_bus)
    );

    muldiv_unit #(
        .MD_BITS_PER_CYCLE (MD_BITS_PER_CYCLE)
    ) u_md (
        .clk (clk),
        .rst (rst),
        .bus (md_bus)
    );

endmodule

`default_nettype wire

// File: hw/ex_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  ex_op_pkg::ex_op_e   op,
    input  ex_types_pkg::xlen_t src1,
    input  ex_types_pkg::xlen_t src2,
    output logic                ack,
    output ex_types_pkg::xlen_t result,
    output logic                cond,
    ex_op_if.ctrl               alu,
    ex_op_if.ctrl               md
);
    import ex_op_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

    logic [1:0] state;
    logic       sel_md;     // op went to mul/div
    logic       unit_done;

    // requester holds these stable while req is high
    assign alu.op = op;
    assign alu.a  = src1;
    assign alu.b  = src2;
    assign md.op  = op;
    assign md.a   = src1;
    assign md.b   = src2;

    assign unit_done = sel_md ? md.done : alu.done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            sel_md    <= 1'b0;
            alu.start <= 1'b0;
            md.start  <= 1'b0;
            ack       <= 1'b0;
            result    <= '0;
            cond      <= 1'b0;
        end else begin
            alu.start <= 1'b0;
            md.start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        sel_md    <= is_muldiv(op);
                        alu.start <= !is_muldiv(op);
                        md.start  <= is_muldiv(op);
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (unit_done) begin
                        result <= sel_md ? md.res : alu.res;
                        cond   <= sel_md ? md.cond : alu.cond;
                        ack    <= 1'b1;
                        state  <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!req) begin  // hold result until req drops
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req)
    );

    a_start_from_idle: assert property (
        @(posedge clk) disable iff (rst)
        (alu.start || md.start) |-> $past(state) == ST_IDLE
    );

endmodule

`default_nettype wire

// File: hw/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit #(
    parameter int MD_BITS_PER_CYCLE = 1
) (
    input  logic  clk,
    input  logic  rst,
    ex_op_if.unit bus
);
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    localparam int ITER = XLEN / MD_BITS_PER_CYCLE;

    logic       busy;
    logic [6:0] cnt;       // iterations left
    ex_op_e     op_q;
    xlen_t      acc;       // product sum or partial remainder
    xlen_t      quo;       // multiplier or dividend/quotient
    xlen_t      dvs;       // multiplicand or divisor
    logic       neg_q;
    logic       neg_r;
    logic       short_q;   // div by zero / overflow result
    xlen_t      short_res;

    logic       sgn;
    logic       is_rem;
    logic       is_mul;
    xlen_t      ext_a;
    xlen_t      ext_b;
    xlen_t      mag_a;
    xlen_t      mag_b;
    logic       div0;
    logic       ovf;
    xlen_t      start_short_res;

    logic        mul_mode;
    xlen_t       nxt_acc;
    xlen_t       nxt_quo;
    xlen_t       nxt_dvs;
    logic [64:0] trial;
    word_u       fin_u;

    // operand setup at start
    always_comb begin
        sgn    = bus.op inside {DIV, REM, DIVW, REMW};
        is_rem = bus.op inside {REM, REMU, REMW, REMUW};
        is_mul = bus.op inside {MUL, MULW};
        if (is_word_op(bus.op)) begin
            ext_a = sgn ? {{HLEN{bus.a[HLEN-1]}}, bus.a[HLEN-1:0]} : {{HLEN{1'b0}}, bus.a[HLEN-1:0]};
            ext_b = sgn ? {{HLEN{bus.b[HLEN-1]}}, bus.b[HLEN-1:0]} : {{HLEN{1'b0}}, bus.b[HLEN-1:0]};
        end else begin
            ext_a = bus.a;
            ext_b = bus.b;
        end
        mag_a = (sgn && ext_a[XLEN-1]) ? -ext_a : ext_a;
        mag_b = (sgn && ext_b[XLEN-1]) ? -ext_b : ext_b;
        div0  = !is_mul && (ext_b == '0);
        ovf   = sgn && (ext_b == '1) &&
                (ext_a == (is_word_op(bus.op) ? HALF_MIN_SEXT : XLEN_MIN));
        if (is_rem) begin
            start_short_res = div0 ? ext_a : '0;
        end else begin
            start_short_res = div0 ? '1 : ext_a;
        end
    end

    assign mul_mode = op_q inside {MUL, MULW};

    // MD_BITS_PER_CYCLE steps of shift-add or restoring subtract
    always_comb begin
        nxt_acc = acc;
        nxt_quo = quo;
        nxt_dvs = dvs;
        trial   = '0;
        for (int i = 0; i < MD_BITS_PER_CYCLE; i++) begin
            if (mul_mode) begin
                if (nxt_quo[0]) begin
                    nxt_acc = nxt_acc + nxt_dvs;
                end
                nxt_dvs = nxt_dvs << 1;
                nxt_quo = nxt_quo >> 1;
            end else begin
                trial   = {nxt_acc, nxt_quo[XLEN-1]};
                nxt_quo = nxt_quo << 1;
                if (trial >= {1'b0, nxt_dvs}) begin
                    trial      = trial - {1'b0, nxt_dvs};
                    nxt_quo[0] = 1'b1;
                end
                nxt_acc = trial[XLEN-1:0];
            end
        end
    end

    // sign fix and W-form extension
    always_comb begin
        if (short_q) begin
            fin_u.word = short_res;
        end else if (mul_mode) begin
            fin_u.word = acc;
        end else if (op_q inside {REM, REMU, REMW, REMUW}) begin
            fin_u.word = neg_r ? -acc : acc;
        end else begin
            fin_u.word = neg_q ? -quo : quo;
        end
        if (is_word_op(op_q)) begin
            fin_u.half.hi = {HLEN{fin_u.half.lo[HLEN-1]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.start) begin
                busy <= 1'b1;
                cnt  <= (div0 || ovf) ? 7'd0 : 7'(ITER);
            end else if (busy) begin
                if (cnt == '0) begin
                    busy     <= 1'b0;
                    bus.done <= 1'b1;
                end else begin
                    cnt <= cnt - 7'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            op_q      <= bus.op;
            acc       <= '0;
            quo       <= is_mul ? ext_b : mag_a;
            dvs       <= is_mul ? ext_a : mag_b;
            neg_q     <= sgn && (ext_a[XLEN-1] ^ ext_b[XLEN-1]);
            neg_r     <= sgn && ext_a[XLEN-1];
            short_q   <= div0 || ovf;
            short_res <= start_short_res;
        end else if (busy && cnt != '0) begin
            acc <= nxt_acc;
            quo <= nxt_quo;
            dvs <= nxt_dvs;
        end
        if (busy && cnt == '0) begin
            bus.res <= fin_u.word;
        end
    end

    assign bus.cond = 1'b0;  // no branch outcome here

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        bus.start |-> !busy
    );

    a_no_done_idle: assert property (
        @(posedge clk) disable iff (rst)
        bus.done |-> $past(busy)
    );

endmodule

`default_nettype wire

// File: hw/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  logic  clk,
    input  logic  rst,
    ex_op_if.unit bus
);
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    logic [5:0] shamt;
    xlen_t      full_res;
    word_u      w_res;
    xlen_t      alu_res;
    logic       taken;

    always_comb begin
        shamt = is_word_op(bus.op) ? {1'b0, bus.b[4:0]} : bus.b[5:0];
        full_res = '0;
        case (bus.op)
            ADD, ADDW: full_res = bus.a + bus.b;
            SUB, SUBW: full_res = bus.a - bus.b;
            AND:       full_res = bus.a & bus.b;
            OR:        full_res = bus.a | bus.b;
            XOR:       full_res = bus.a ^ bus.b;
            SLL, SLLW: full_res = bus.a << shamt;
            SRL:       full_res = bus.a >> shamt;
            SRLW:      full_res = {{HLEN{1'b0}}, bus.a[HLEN-1:0]} >> shamt;
            SRA:       full_res = $signed(bus.a) >>> shamt;
            SRAW:      full_res = $signed({{HLEN{bus.a[HLEN-1]}}, bus.a[HLEN-1:0]}) >>> shamt;
            SLT:       full_res = {{(XLEN-1){1'b0}}, $signed(bus.a) < $signed(bus.b)};
            SLTU:      full_res = {{(XLEN-1){1'b0}}, bus.a < bus.b};
            default:   full_res = '0;
        endcase

        w_res.word = full_res;
        if (is_word_op(bus.op)) begin
            w_res.half.hi = {HLEN{w_res.half.lo[HLEN-1]}};  // sign-extend low half
        end
    end

    // 1 when the branch is taken
    always_comb begin
        case (bus.op)
            BEQ:     taken = bus.a == bus.b;
            BNE:     taken = bus.a != bus.b;
            BLT:     taken = $signed(bus.a) < $signed(bus.b);
            BGE:     taken = $signed(bus.a) >= $signed(bus.b);
            BLTU:    taken = bus.a < bus.b;
            BGEU:    taken = bus.a >= bus.b;
            default: taken = 1'b0;
        endcase
    end

    assign alu_res = is_branch(bus.op) ? '0 : w_res.word;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.start;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            bus.res  <= alu_res;
            bus.cond <= taken;
        end
    end

    // valid result one cycle after start
    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        bus.start |=> bus.done && !$isunknown({bus.res, bus.cond})
    );

endmodule

`default_nettype wire

// File: hw/ex_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_op_if;
    import ex_types_pkg::*;
    import ex_op_pkg::*;

    logic   start;  // one-cycle pulse, op/a/b valid
    ex_op_e op;
    xlen_t  a;
    xlen_t  b;
    logic   done;   // one-cycle pulse, res/cond valid
    xlen_t  res;
    logic   cond;

    modport ctrl (
        output start, op, a, b,
        input  done, res, cond
    );

    modport unit (
        input  start, op, a, b,
        output done, res, cond
    );
endinterface

`default_nettype wire

// File: hw/ex_op_pkg.sv
`default_nettype none

package ex_op_pkg;

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        MUL, MULW, DIV, DIVU, REM, REMU,
        DIVW, DIVUW, REMW, REMUW
    } ex_op_e;

    // ops handled by the iterative unit
    function automatic logic is_muldiv(ex_op_e op);
        return op inside {MUL, MULW, DIV, DIVU, REM, REMU,
                          DIVW, DIVUW, REMW, REMUW};
    endfunction

    // 32-bit forms, result sign-extended from bit 31
    function automatic logic is_word_op(ex_op_e op);
        return op inside {ADDW, SUBW, SLLW, SRLW, SRAW,
                          MULW, DIVW, DIVUW, REMW, REMUW};
    endfunction

    function automatic logic is_branch(ex_op_e op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

endpackage

`default_nettype wire

// File: hw/ex_types_pkg.sv
`default_nettype none

package ex_types_pkg;

    localparam int XLEN = 64;
    localparam int HLEN = XLEN / 2;

    // one register-width data word
    typedef logic [XLEN-1:0] xlen_t;

    // upper or lower half of a word
    typedef logic [HLEN-1:0] half_t;

    typedef struct packed {
        half_t hi;
        half_t lo;
    } word_halves_t;

    // same 64 bits, seen whole or as two halves
    typedef union packed {
        xlen_t        word;
        word_halves_t half;
    } word_u;

    // most negative 64-bit value
    localparam xlen_t XLEN_MIN = {1'b1, {(XLEN-1){1'b0}}};

    // most negative 32-bit value, sign-extended
    localparam xlen_t HALF_MIN_SEXT = {{(HLEN+1){1'b1}}, {(HLEN-1){1'b0}}};

endpackage

`default_nettype wire
